//--- rtl/clear_lfsr.sv
`timescale 1ns/100ps
`default_nettype none

module clear_lfsr (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  seed_en_i,
  input  wire logic [prng_clear_pkg::PRNG_WIDTH-1:0] seed_i,
  input  wire logic                                  lfsr_en_i,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]      state_o
);

  localparam int unsigned W = prng_clear_pkg::PRNG_WIDTH;

  // Number of 4-bit S-boxes in the nonlinear layer.
  localparam int unsigned NUM_SBOX = W / 4;

  logic [W-1:0] lfsr_q;
  logic [W-1:0] lfsr_d;
  logic [W-1:0] lfsr_step;

  // Intermediate values of the output path.
  logic [W-1:0] perm_in;
  logic [W-1:0] sbox_out;

  // One Galois step.
  // The state shifts right, and the taps are folded in when a one drops out at bit 0.
  always_comb begin
    lfsr_step = {1'b0, lfsr_q[W-1:1]};
    if (lfsr_q[0]) begin
      lfsr_step = lfsr_step ^ prng_clear_pkg::LFSR_TAPS;
    end
  end

  // Next-state selection.
  // A reseed wins over a step in the same cycle, so fresh entropy is never lost.
  always_comb begin
    lfsr_d = lfsr_q;
    if (seed_en_i) begin
      lfsr_d = seed_i;
    end else if (lfsr_en_i) begin
      lfsr_d = lfsr_step;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= prng_clear_pkg::LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // First permutation of the output path.
  // It scatters neighbouring state bits across different S-boxes.
  always_comb begin
    for (int i = 0; i < W; i++) begin
      perm_in[i] = lfsr_q[prng_clear_pkg::LFSR_PERM[i]];
    end
  end

  // Nonlinear layer.
  // Each nibble passes through its own copy of the PRINCE S-box.
  always_comb begin
    for (int n = 0; n < NUM_SBOX; n++) begin
      sbox_out[4*n +: 4] = prng_clear_pkg::PRINCE_SBOX[perm_in[4*n +: 4]];
    end
  end

  // Second permutation with the same table.
  // This spreads each S-box result over the whole output word.
  always_comb begin
    for (int i = 0; i < W; i++) begin
      state_o[i] = sbox_out[prng_clear_pkg::LFSR_PERM[i]];
    end
  end

endmodule

`default_nettype wire

//--- rtl/entropy_packer.sv
`timescale 1ns/100ps
`default_nettype none

module entropy_packer (
  input  wire logic                                     clk_i,
  input  wire logic                                     rst_ni,
  input  wire logic                                     reseed_req_i,
  output logic                                          entropy_req_o,
  input  wire logic                                     entropy_ack_i,
  input  wire logic [prng_clear_pkg::ENTROPY_WIDTH-1:0] entropy_i,
  output logic                                          seed_valid_o,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]         seed_o
);

  // Holds the first entropy word of a seed until the second one arrives.
  logic [prng_clear_pkg::ENTROPY_WIDTH-1:0] buffer_q;
  logic                                     buffer_valid_q;

  // High on every edge where an entropy word is handed over.
  logic entropy_fire;

  // Entropy is requested for as long as a reseed is pending.
  // The requester drops reseed_req_i after the acknowledge, so the request
  // goes low in the cycle after the seed is complete.
  assign entropy_req_o = reseed_req_i;

  assign entropy_fire = entropy_req_o & entropy_ack_i;

  // The first word forms the upper half of the seed, the live word the lower half.
  assign seed_o = {buffer_q, entropy_i};

  // The seed is complete with the second accepted word, in the same cycle.
  assign seed_valid_o = buffer_valid_q & entropy_fire;

  // Buffer-valid flag.
  // It toggles with every accepted word, so the second word clears it again.
  // A reseed request that is withdrawn halfway also drops a half-filled buffer,
  // which keeps a stale word out of the next seed.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buffer_valid_q <= 1'b0;
    end else if (!reseed_req_i) begin
      buffer_valid_q <= 1'b0;
    end else if (entropy_fire) begin
      buffer_valid_q <= ~buffer_valid_q;
    end
  end

  // Data buffer.
  // Only the first word of a pair is stored here.
  always_ff @(posedge clk_i) begin
    if (entropy_fire && !buffer_valid_q) begin
      buffer_q <= entropy_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/key_share_wiper.sv
`timescale 1ns/100ps
`default_nettype none

module key_share_wiper (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  key_load_i,
  input  wire logic [prng_clear_pkg::PRNG_WIDTH-1:0] key_i,
  input  wire logic                                  wipe_i,
  output logic                                       wipe_done_o,
  output logic                                       data_req_o,
  input  wire logic                                  data_ack_i,
  input  wire logic [prng_clear_pkg::PRNG_WIDTH-1:0] data0_i,
  input  wire logic [prng_clear_pkg::PRNG_WIDTH-1:0] data1_i,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]      share0_o,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]      share1_o
);

  localparam int unsigned W = prng_clear_pkg::PRNG_WIDTH;

  logic [W-1:0] share0_q;
  logic [W-1:0] share1_q;
  logic         wipe_pending_q;
  logic         wipe_done_q;

  // High on the edge where PRNG data is taken into both shares.
  logic         wipe_fire;

  // PRNG data is only requested while a wipe is outstanding.
  assign data_req_o = wipe_pending_q;
  assign wipe_fire  = data_req_o & data_ack_i;

  // Wipe-pending flag.
  // A new wipe pulse wins over completion, so a pulse in the completing
  // cycle still leads to a further overwrite.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wipe_pending_q <= 1'b0;
    end else if (wipe_i) begin
      wipe_pending_q <= 1'b1;
    end else if (wipe_fire) begin
      wipe_pending_q <= 1'b0;
    end
  end

  // Completion strobe.
  // It rises together with the wiped share values.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wipe_done_q <= 1'b0;
    end else begin
      wipe_done_q <= wipe_fire;
    end
  end

  // Share registers.
  // A wipe overwrites both shares with fresh PRNG data.
  // A key load stores the key unmasked in share 0 with a zero share 1.
  // Loads are dropped while a wipe is pending, so a key cannot slip in
  // between the wipe request and its completion.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      share0_q <= '0;
      share1_q <= '0;
    end else if (wipe_fire) begin
      share0_q <= data0_i;
      share1_q <= data1_i;
    end else if (key_load_i && !wipe_pending_q) begin
      share0_q <= key_i;
      share1_q <= '0;
    end
  end

  assign share0_o    = share0_q;
  assign share1_o    = share1_q;
  assign wipe_done_o = wipe_done_q;

endmodule

`default_nettype wire

//--- rtl/prng_clear_pkg.sv
`default_nettype none

package prng_clear_pkg;

  // Width of the LFSR state and of each pseudo-random output share.
  localparam int unsigned PRNG_WIDTH = 64;

  // Width of one entropy word. Two words make up one full seed.
  localparam int unsigned ENTROPY_WIDTH = 32;

  // Reset value of the LFSR state.
  // It must not be all zero, since the all-zero state is a fixed point of the LFSR.
  localparam logic [PRNG_WIDTH-1:0] LFSR_SEED = 64'h3a7c_91e5_0f26_d84b;

  // Galois feedback mask for a right-shifting LFSR.
  // The mask is XORed into the shifted state whenever the bit shifted out was one.
  // It encodes the polynomial x^64 + x^63 + x^61 + x^60 + 1.
  localparam logic [PRNG_WIDTH-1:0] LFSR_TAPS = 64'hd800_0000_0000_0000;

  // Bit permutation on the LFSR output path.
  // Output bit i takes input bit LFSR_PERM[i].
  // The same table is applied before and after the S-box layer.
  localparam int unsigned LFSR_PERM [PRNG_WIDTH] = '{
     5, 28, 51, 10, 33, 56, 15, 38, 61, 20, 43,  2, 25, 48,  7, 30,
    53, 12, 35, 58, 17, 40, 63, 22, 45,  4, 27, 50,  9, 32, 55, 14,
    37, 60, 19, 42,  1, 24, 47,  6, 29, 52, 11, 34, 57, 16, 39, 62,
    21, 44,  3, 26, 49,  8, 31, 54, 13, 36, 59, 18, 41,  0, 23, 46
  };

  // Bit permutation that derives the second share from the first one.
  // Output bit i takes input bit SHARE_PERM[i].
  localparam int unsigned SHARE_PERM [PRNG_WIDTH] = '{
    11, 48, 21, 58, 31,  4, 41, 14, 51, 24, 61, 34,  7, 44, 17, 54,
    27,  0, 37, 10, 47, 20, 57, 30,  3, 40, 13, 50, 23, 60, 33,  6,
    43, 16, 53, 26, 63, 36,  9, 46, 19, 56, 29,  2, 39, 12, 49, 22,
    59, 32,  5, 42, 15, 52, 25, 62, 35,  8, 45, 18, 55, 28,  1, 38
  };

  // The 4-bit S-box of the PRINCE block cipher.
  // It is applied to every nibble of the permuted LFSR state.
  localparam logic [3:0] PRINCE_SBOX [16] = '{
    4'hb, 4'hf, 4'h3, 4'h2, 4'ha, 4'hc, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'he, 4'h5, 4'hd, 4'h4
  };

endpackage

`default_nettype wire

//--- rtl/prng_clear_top.sv
`timescale 1ns/100ps
`default_nettype none

module prng_clear_top (
  input  wire logic                                     clk_i,
  input  wire logic                                     rst_ni,
  input  wire logic                                     reseed_req_i,
  output logic                                          reseed_ack_o,
  output logic                                          entropy_req_o,
  input  wire logic                                     entropy_ack_i,
  input  wire logic [prng_clear_pkg::ENTROPY_WIDTH-1:0] entropy_i,
  input  wire logic                                     key_load_i,
  input  wire logic [prng_clear_pkg::PRNG_WIDTH-1:0]    key_i,
  input  wire logic                                     wipe_i,
  output logic                                          wipe_done_o,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]         share0_o,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]         share1_o
);

  localparam int unsigned W = prng_clear_pkg::PRNG_WIDTH;

  // Packed seed from the entropy side into the PRNG.
  logic         seed_valid;
  logic [W-1:0] seed;

  // Data handshake and both PRNG shares towards the key register.
  logic         data_req;
  logic         data_ack;
  logic [W-1:0] data0;
  logic [W-1:0] data1;

  entropy_packer u_entropy_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_req_i  (reseed_req_i),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .seed_valid_o  (seed_valid),
    .seed_o        (seed)
  );

  prng_clearing u_prng_clearing (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req),
    .data_ack_o   (data_ack),
    .data0_o      (data0),
    .data1_o      (data1),
    .reseed_req_i (reseed_req_i),
    .reseed_ack_o (reseed_ack_o),
    .seed_valid_i (seed_valid),
    .seed_i       (seed)
  );

  key_share_wiper u_key_share_wiper (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_load_i  (key_load_i),
    .key_i       (key_i),
    .wipe_i      (wipe_i),
    .wipe_done_o (wipe_done_o),
    .data_req_o  (data_req),
    .data_ack_i  (data_ack),
    .data0_i     (data0),
    .data1_i     (data1),
    .share0_o    (share0_o),
    .share1_o    (share1_o)
  );

endmodule

`default_nettype wire

//--- rtl/prng_clearing.sv
`timescale 1ns/100ps
`default_nettype none

module prng_clearing (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  data_req_i,
  output logic                                       data_ack_o,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]      data0_o,
  output logic [prng_clear_pkg::PRNG_WIDTH-1:0]      data1_o,
  input  wire logic                                  reseed_req_i,
  output logic                                       reseed_ack_o,
  input  wire logic                                  seed_valid_i,
  input  wire logic [prng_clear_pkg::PRNG_WIDTH-1:0] seed_i
);

  localparam int unsigned W = prng_clear_pkg::PRNG_WIDTH;

  logic         lfsr_en;
  logic [W-1:0] lfsr_state;

  // Reseeding has priority over data.
  // While a reseed is pending every data request is held off, so no clearing
  // value is taken from a state that is about to be replaced.
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // The LFSR advances once per handed-out value, so no value is reused.
  assign lfsr_en = data_req_i & data_ack_o;

  // The reseed completes on the edge where the packed seed is loaded.
  assign reseed_ack_o = seed_valid_i;

  clear_lfsr u_clear_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .seed_en_i (seed_valid_i),
    .seed_i    (seed_i),
    .lfsr_en_i (lfsr_en),
    .state_o   (lfsr_state)
  );

  // Share 0 is the nonlinear LFSR output as it is.
  assign data0_o = lfsr_state;

  // Share 1 is a fixed bit permutation of share 0.
  // Both shares of a register thus get different bit patterns from one LFSR.
  always_comb begin
    for (int i = 0; i < W; i++) begin
      data1_o[i] = lfsr_state[prng_clear_pkg::SHARE_PERM[i]];
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim
output=$(./obj_dir/tb_sim 2>&1 || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+tests
rtl/prng_clear_pkg.sv
rtl/clear_lfsr.sv
rtl/entropy_packer.sv
rtl/prng_clearing.sv
rtl/key_share_wiper.sv
rtl/prng_clear_top.sv
tests/tb_top.sv

//--- tests/prng_model.svh
`ifndef PRNG_MODEL_SVH
`define PRNG_MODEL_SVH

// Reference model of the clearing PRNG.
// Each function follows one rule of the PRNG on its own, without any clocking.

// One Galois step of the 64-bit LFSR.
// The state shifts right by one, and the taps are XORed in when the old bit 0 was set.
function automatic logic [63:0] lfsr_advance(input logic [63:0] s);
  logic [63:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ prng_clear_pkg::LFSR_TAPS;
  end
  return n;
endfunction

// Share 0 of a given LFSR state.
// The state is permuted, every nibble goes through the PRINCE S-box, then the
// result is permuted again with the same table.
function automatic logic [63:0] output_path(input logic [63:0] s);
  logic [63:0] p;
  logic [63:0] x;
  logic [63:0] r;
  logic [5:0]  idx;
  for (int i = 0; i < 64; i++) begin
    idx  = 6'(prng_clear_pkg::LFSR_PERM[i]);
    p[i] = s[idx];
  end
  for (int n = 0; n < 16; n++) begin
    x[4*n +: 4] = prng_clear_pkg::PRINCE_SBOX[p[4*n +: 4]];
  end
  for (int i = 0; i < 64; i++) begin
    idx  = 6'(prng_clear_pkg::LFSR_PERM[i]);
    r[i] = x[idx];
  end
  return r;
endfunction

// Share 1 is share 0 with its bits reordered by SHARE_PERM.
function automatic logic [63:0] share_permute(input logic [63:0] d0);
  logic [63:0] r;
  logic [5:0]  idx;
  for (int i = 0; i < 64; i++) begin
    idx  = 6'(prng_clear_pkg::SHARE_PERM[i]);
    r[i] = d0[idx];
  end
  return r;
endfunction

`endif

//--- tests/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "prng_model.svh"

module tb_top;

  // Upper bound for every wait loop, in clock cycles.
  localparam int WAIT_LIMIT = 40;

  logic        clk_i;
  logic        rst_ni;
  logic        reseed_req_i;
  logic        reseed_ack_o;
  logic        entropy_req_o;
  logic        entropy_ack_i;
  logic [31:0] entropy_i;
  logic        key_load_i;
  logic [63:0] key_i;
  logic        wipe_i;
  logic        wipe_done_o;
  logic [63:0] share0_o;
  logic [63:0] share1_o;

  // Expected LFSR state of the DUT and state of the entropy generator.
  logic [63:0] model_state;
  logic [31:0] rng_state;
  // Goes high once reseed_ack_o has been observed.
  logic        reseed_seen;
  // Every share 0 value produced by a wipe so far.
  logic [63:0] seen_values [$];

  prng_clear_top dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .key_load_i    (key_load_i),
    .key_i         (key_i),
    .wipe_i        (wipe_i),
    .wipe_done_o   (wipe_done_o),
    .share0_o      (share0_o),
    .share1_o      (share1_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Galois LFSR for the entropy words with the polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] entropy_lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // Builds one entropy word, one LFSR step per bit.
  task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], rng_state[0]};
      rng_state = entropy_lfsr_next(rng_state);
    end
  endtask

  // Each table must name every bit exactly once.
  task automatic check_perm_tables;
    int lfsr_hits [64];
    int share_hits [64];
    foreach (lfsr_hits[i]) begin
      lfsr_hits[i]  = 0;
      share_hits[i] = 0;
    end
    for (int i = 0; i < 64; i++) begin
      lfsr_hits[6'(prng_clear_pkg::LFSR_PERM[i])]++;
      share_hits[6'(prng_clear_pkg::SHARE_PERM[i])]++;
    end
    for (int i = 0; i < 64; i++) begin
      if (lfsr_hits[i] != 1 || share_hits[i] != 1) begin
        stop_on_error($sformatf("A permutation table does not use bit %0d exactly once", i));
      end
    end
  endtask

  // Pulses wipe_i for one cycle and counts the cycles up to wipe_done_o.
  task automatic pulse_wipe(output int latency);
    latency = 0;
    wipe_i  = 1'b1;
    do begin
      @(negedge clk_i);
      wipe_i = 1'b0;
      latency++;
      if (latency > WAIT_LIMIT) begin
        stop_on_error("Timeout while waiting for wipe_done_o after a wipe pulse");
      end
    end while (!wipe_done_o);
  endtask

  // Both shares must match the model; then the model steps once.
  task automatic check_wiped_shares;
    logic [63:0] exp0;
    exp0 = output_path(model_state);
    check_value("share0_o", share0_o, exp0);
    check_value("share1_o", share1_o, share_permute(exp0));
    foreach (seen_values[k]) begin
      if (seen_values[k] === share0_o) begin
        stop_on_error("A wipe repeated a share 0 value of an earlier wipe");
      end
    end
    seen_values.push_back(share0_o);
    model_state = lfsr_advance(model_state);
  endtask

  // Serves two entropy words, each after gap idle cycles of entropy_ack_i.
  // The first word becomes the upper half of the seed.
  task automatic run_reseed(input int gap, output int ack_cycle);
    logic [31:0] w0;
    logic [31:0] w1;
    int          cycle;
    int          taken;
    int          idle;
    draw_word(w0);
    draw_word(w1);
    cycle        = 0;
    taken        = 0;
    idle         = 0;
    ack_cycle    = 0;
    reseed_req_i = 1'b1;
    while (ack_cycle == 0) begin
      cycle++;
      if (cycle > WAIT_LIMIT) begin
        stop_on_error("Timeout while waiting for reseed_ack_o");
      end
      entropy_ack_i = (idle >= gap);
      entropy_i     = (taken == 0) ? w0 : w1;
      #1;
      check_value("entropy_req_o", 64'(entropy_req_o), 64'd1);
      if (reseed_ack_o) begin
        ack_cycle   = cycle;
        reseed_seen = 1'b1;
      end
      if (entropy_ack_i) begin
        taken++;
        idle = 0;
      end else begin
        idle++;
      end
      @(negedge clk_i);
    end
    reseed_req_i  = 1'b0;
    entropy_ack_i = 1'b0;
    model_state   = {w0, w1};
    #1;
    check_value("entropy_req_o", 64'(entropy_req_o), 64'd0);
    check_value("reseed_ack_o", 64'(reseed_ack_o), 64'd0);
  endtask

  task automatic reset_values;
    check_value("share0_o", share0_o, 64'h0);
    check_value("share1_o", share1_o, 64'h0);
    check_value("entropy_req_o", 64'(entropy_req_o), 64'h0);
    check_value("reseed_ack_o", 64'(reseed_ack_o), 64'h0);
    check_value("wipe_done_o", 64'(wipe_done_o), 64'h0);
  endtask

  // Runs after a wipe, so share 1 holds PRNG data that the load must clear.
  task automatic key_load;
    key_i      = 64'hc0de_5eed_1234_abcd;
    key_load_i = 1'b1;
    @(negedge clk_i);
    key_load_i = 1'b0;
    check_value("share0_o", share0_o, 64'hc0de_5eed_1234_abcd);
    check_value("share1_o", share1_o, 64'h0);
  endtask

  // The model still holds LFSR_SEED here.
  task automatic wipe_from_reset_seed;
    int latency;
    pulse_wipe(latency);
    check_value("wipe latency", 64'(latency), 64'd2);
    check_wiped_shares();
    @(negedge clk_i);
    check_value("wipe_done_o", 64'(wipe_done_o), 64'h0);
  endtask

  task automatic back_to_back_wipes;
    int latency;
    for (int k = 0; k < 3; k++) begin
      pulse_wipe(latency);
      check_value("wipe latency", 64'(latency), 64'd2);
      check_wiped_shares();
    end
  endtask

  task automatic reseed_from_entropy;
    int ack_cycle;
    int latency;
    @(negedge clk_i);
    run_reseed(0, ack_cycle);
    check_value("reseed_ack_o cycle", 64'(ack_cycle), 64'd2);
    @(negedge clk_i);
    pulse_wipe(latency);
    check_value("wipe latency", 64'(latency), 64'd2);
    check_wiped_shares();
  endtask

  // The wipe starts one cycle into the reseed and must wait for its acknowledge.
  task automatic reseed_priority;
    int ack_cycle;
    int latency;
    reseed_seen = 1'b0;
    @(negedge clk_i);
    fork
      run_reseed(3, ack_cycle);
      begin
        @(negedge clk_i);
        pulse_wipe(latency);
        check_value("reseed_ack_o seen before wipe_done_o", 64'(reseed_seen), 64'd1);
      end
    join
    check_value("reseed_ack_o cycle", 64'(ack_cycle), 64'd8);
    check_wiped_shares();
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    reseed_req_i  = 1'b0;
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    key_load_i    = 1'b0;
    key_i         = '0;
    wipe_i        = 1'b0;
    reseed_seen   = 1'b0;
    rng_state     = 32'h68cb_2399;
    model_state   = prng_clear_pkg::LFSR_SEED;
    check_perm_tables();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_values();
    wipe_from_reset_seed();
    key_load();
    back_to_back_wipes();
    reseed_from_entropy();
    reseed_priority();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
